// ==== synth_config.svh ====
`ifndef SYNTH_CONFIG_SVH
`define SYNTH_CONFIG_SVH

// note index, 0 to 63
`define SYNTH_NOTE_W 6
// phase accumulator width
`define SYNTH_PHASE_W 20
// register data word and period width
`define SYNTH_WORD_W 16
// step index width
`define SYNTH_STEP_W 4
// one waveform sample
`define SYNTH_SAMPLE_W 4
// mixed audio output
`define SYNTH_AUDIO_W 8

`define SYNTH_SEQ_LEN 10          // steps in the note table
`define SYNTH_PERIOD_RESET 200    // clk cycles per step after reset
`define SYNTH_GLIDE_DIV 16        // clk cycles per portamento semitone

// run 0, glide off, vol 0, all four channels on
`define SYNTH_CTRL_RESET 16'h0F00

`endif

// ==== synth_pkg.sv ====
`include "synth_config.svh"

package synth_pkg;

	// control register, msb first
	typedef struct packed {
		logic run;              // sequencer runs
		logic glide_en;         // portamento allowed
		logic [1:0] vol;        // output scale vol+1
		logic [3:0] chan_en;    // lead sq, lead tri, bass sq, bass tri
		logic [7:0] spare;
	} ctrl_t;

	// one register word, meaning depends on address
	typedef union packed {
		logic [`SYNTH_WORD_W-1:0] period;   // address 0
		ctrl_t ctrl;                        // address 1
	} cfg_word_u;

	typedef struct packed {
		logic [`SYNTH_STEP_W-1:0] step;
		logic [`SYNTH_NOTE_W-1:0] target;
		logic [`SYNTH_NOTE_W-1:0] lead;
	} status_t;

	typedef struct packed {
		logic [`SYNTH_SAMPLE_W-1:0] square;
		logic [`SYNTH_SAMPLE_W-1:0] triangle;
	} voice_t;

	typedef struct packed {
		logic [`SYNTH_NOTE_W-1:0] note;
		logic glide;            // step asks for a slide
	} seq_entry_t;

	// demo tune, glide off only on steps 2 and 3
	localparam seq_entry_t seq_table [`SYNTH_SEQ_LEN] = '{
		'{6'd12, 1'b1}, '{6'd24, 1'b1}, '{6'd36, 1'b0}, '{6'd24, 1'b0}, '{6'd36, 1'b1},
		'{6'd36, 1'b1}, '{6'd24, 1'b1}, '{6'd24, 1'b1}, '{6'd12, 1'b1}, '{6'd0, 1'b1}
	};

	// octave 0 increments, each about 2^(1/12) above the last
	localparam logic [`SYNTH_PHASE_W-1:0] semi_inc [12] = '{
		20'd64, 20'd68, 20'd72, 20'd76, 20'd81, 20'd85,
		20'd91, 20'd96, 20'd102, 20'd108, 20'd114, 20'd121
	};

endpackage

// ==== synth_regs.sv ====
`timescale 1ns/10ps
`include "synth_config.svh"

module synth_regs
	import synth_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic [1:0] cfg_addr,
	input logic cfg_wr,
	input logic cfg_rd,
	input cfg_word_u cfg_wdata,
	input status_t status,              // live view from the datapath
	output logic [`SYNTH_WORD_W-1:0] cfg_rdata,
	output logic [`SYNTH_WORD_W-1:0] period,
	output ctrl_t ctrl
);

	localparam logic [1:0] ADDR_PERIOD = 2'd0;
	localparam logic [1:0] ADDR_CTRL = 2'd1;
	localparam logic [1:0] ADDR_STATUS = 2'd2;

	logic [`SYNTH_WORD_W-1:0] rd_mux;

	// writes, same word decoded two ways
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			period <= `SYNTH_PERIOD_RESET;
			ctrl <= ctrl_t'(`SYNTH_CTRL_RESET);
		end
		else if (cfg_wr)
		begin
			if (cfg_addr == ADDR_PERIOD)
				period <= cfg_wdata.period;     // raw cycle count
			else if (cfg_addr == ADDR_CTRL)
				ctrl <= cfg_wdata.ctrl;         // field view
		end
	end

	always_comb
	begin
		case (cfg_addr)
			ADDR_PERIOD: rd_mux = period;
			ADDR_CTRL: rd_mux = ctrl;
			ADDR_STATUS: rd_mux = status;
			default: rd_mux = '0;               // unmapped
		endcase
	end

	// read data one cycle after strobe, zero otherwise
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			cfg_rdata <= '0;
		else
			cfg_rdata <= cfg_rd ? rd_mux : '0;
	end

	// zero period would stall the step counter forever
	a_period_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
		(cfg_wr && cfg_addr == ADDR_PERIOD) |=> (period != '0))
		else $error("step period written as zero");

endmodule

// ==== note_sequencer.sv ====
`timescale 1ns/10ps
`include "synth_config.svh"

module note_sequencer
	import synth_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic run,
	input logic restart,                    // clears step, loads entry 0
	input logic [`SYNTH_WORD_W-1:0] period,
	output seq_entry_t target,
	output logic [`SYNTH_STEP_W-1:0] step,
	output logic step_tick                  // flips on every step
);

	logic [`SYNTH_WORD_W-1:0] cnt;          // cycles within a step
	logic [`SYNTH_STEP_W-1:0] step_next;
	logic last;

	// end of step period
	assign last = (cnt == period - 1'b1);

	always_comb
	begin
		if (step == `SYNTH_SEQ_LEN - 1)
			step_next = '0;                 // wrap after last entry
		else
			step_next = step + 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cnt <= '0;
			step <= '0;
			step_tick <= 1'b0;
			target <= '0;                   // note 0, no glide
		end
		else if (restart)
		begin
			// restart beats run
			cnt <= '0;
			step <= '0;
			step_tick <= 1'b0;
			target <= seq_table[0];
		end
		else if (run)
		begin
			if (last)
			begin
				cnt <= '0;
				step <= step_next;
				target <= seq_table[step_next];   // note and glide request
				step_tick <= ~step_tick;
			end
			else
			begin
				cnt <= cnt + 1'b1;
			end
		end
		// run low holds everything
	end

	// index must stay inside the ten entry table
	a_step_range: assert property (@(posedge clk) disable iff (!arst_n)
		step < `SYNTH_SEQ_LEN)
		else $error("step index out of table range");

endmodule

// ==== portamento.sv ====
`timescale 1ns/10ps
`include "synth_config.svh"

module portamento
	import synth_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input seq_entry_t target,
	input logic glide_en,
	output logic [`SYNTH_NOTE_W-1:0] lead_note
);

	localparam int DIV_W = $clog2(`SYNTH_GLIDE_DIV);

	logic [DIV_W-1:0] div;                  // glide interval counter
	logic [`SYNTH_NOTE_W-1:0] prev_note;    // target one cycle back
	logic gliding;
	logic tgt_chg;

	assign gliding = glide_en && target.glide;
	assign tgt_chg = (target.note != prev_note);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			lead_note <= '0;
			div <= '0;
			prev_note <= '0;
		end
		else
		begin
			prev_note <= target.note;
			if (!gliding)
			begin
				lead_note <= target.note;   // straight jump
				div <= '0;
			end
			else if (tgt_chg)
				div <= '0;                  // new note, fresh interval
			else if (div == DIV_W'(`SYNTH_GLIDE_DIV - 1))
			begin
				div <= '0;
				if (lead_note < target.note)
					lead_note <= lead_note + 1'b1;
				else if (lead_note > target.note)
					lead_note <= lead_note - 1'b1;
			end
			else
				div <= div + 1'b1;
		end
	end

	a_one_semi: assert property (@(posedge clk) disable iff (!arst_n)
		gliding |=> (lead_note == $past(lead_note) ||
			lead_note == $past(lead_note) + 6'd1 ||
			lead_note == $past(lead_note) - 6'd1))
		else $error("glide moved more than one semitone");

endmodule

// ==== tone_osc.sv ====
`timescale 1ns/10ps
`include "synth_config.svh"

module tone_osc
	import synth_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic [`SYNTH_NOTE_W-1:0] note,
	output voice_t voice
);

	localparam int PW = `SYNTH_PHASE_W;

	logic [PW-1:0] phase;
	logic [PW-1:0] inc;                     // per-cycle phase step
	logic [3:0] semi;                       // note within octave
	logic [2:0] oct;                        // octave above 0
	logic [4:0] top5;                       // upper phase bits for triangle

	// note to increment, octave is a left shift
	always_comb
	begin
		semi = 4'(note % 6'd12);
		oct = 3'(note / 6'd12);
		inc = semi_inc[semi] << oct;
	end

	// free-running accumulator, wraps naturally
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			phase <= '0;
		else
			phase <= phase + inc;
	end

	assign top5 = phase[PW-1 -: 5];

	// wave shaping straight off the phase register
	always_comb
	begin
		// square, full scale in upper half
		if (phase[PW-1])
			voice.square = 4'hF;
		else
			voice.square = 4'h0;
		// triangle, rising then mirrored
		if (top5[4])
			voice.triangle = ~top5[3:0];
		else
			voice.triangle = top5[3:0];
	end

endmodule

// ==== voice_mixer.sv ====
`timescale 1ns/10ps
`include "synth_config.svh"

module voice_mixer
	import synth_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input voice_t lead,
	input voice_t bass,
	input logic [3:0] chan_en,              // lead sq, lead tri, bass sq, bass tri
	input logic [1:0] vol,
	output logic [`SYNTH_AUDIO_W-1:0] audio_out
);

	logic [5:0] sum;                        // four 4-bit samples, max 60
	logic [`SYNTH_AUDIO_W-1:0] scaled;      // max 240

	always_comb
	begin
		sum = '0;
		if (chan_en[3])
			sum = sum + {2'b00, lead.square};
		if (chan_en[2])
			sum = sum + {2'b00, lead.triangle};
		if (chan_en[1])
			sum = sum + {2'b00, bass.square};
		if (chan_en[0])
			sum = sum + {2'b00, bass.triangle};
		scaled = {2'b00, sum} * ({6'd0, vol} + 8'd1);   // vol 0 is x1
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			audio_out <= '0;
		else
			audio_out <= scaled;
	end

	// keeps the x4 product inside 8 bits
	a_sum_max: assert property (@(posedge clk) disable iff (!arst_n)
		sum <= 6'd60)
		else $error("mixer sum above 60");

endmodule

// ==== synth_top.sv ====
`timescale 1ns/10ps
`include "synth_config.svh"

module synth_top
	import synth_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic restart,
	input logic [1:0] cfg_addr,
	input logic cfg_wr,
	input cfg_word_u cfg_wdata,
	input logic cfg_rd,
	output logic [`SYNTH_WORD_W-1:0] cfg_rdata,
	output logic [`SYNTH_AUDIO_W-1:0] audio_out,
	output logic step_tick
);

	logic [`SYNTH_WORD_W-1:0] period;
	ctrl_t ctrl;
	status_t status;
	seq_entry_t target;
	logic [`SYNTH_STEP_W-1:0] step;
	logic [`SYNTH_NOTE_W-1:0] lead_note;
	logic [`SYNTH_NOTE_W-1:0] bass_note;    // octave below target
	voice_t lead_v;
	voice_t bass_v;

	// bass drops an octave, floored at note 0
	assign bass_note = (target.note >= 6'd12) ? target.note - 6'd12 : '0;

	assign status.step = step;
	assign status.target = target.note;
	assign status.lead = lead_note;

	synth_regs u_regs (.clk(clk), .arst_n(arst_n), .cfg_addr(cfg_addr), .cfg_wr(cfg_wr),
		.cfg_rd(cfg_rd), .cfg_wdata(cfg_wdata), .status(status), .cfg_rdata(cfg_rdata),
		.period(period), .ctrl(ctrl));

	note_sequencer u_seq (.clk(clk), .arst_n(arst_n), .run(ctrl.run), .restart(restart),
		.period(period), .target(target), .step(step), .step_tick(step_tick));

	portamento u_porta (.clk(clk), .arst_n(arst_n), .target(target),
		.glide_en(ctrl.glide_en), .lead_note(lead_note));

	// lead follows the slide
	tone_osc u_lead_osc (.clk(clk), .arst_n(arst_n), .note(lead_note), .voice(lead_v));

	// bass jumps straight to its note
	tone_osc u_bass_osc (.clk(clk), .arst_n(arst_n), .note(bass_note), .voice(bass_v));

	voice_mixer u_mix (.clk(clk), .arst_n(arst_n), .lead(lead_v), .bass(bass_v),
		.chan_en(ctrl.chan_en), .vol(ctrl.vol), .audio_out(audio_out));

endmodule

// ==== tb_synth.sv ====
`timescale 1ns/10ps
`include "synth_config.svh"

module tb_synth
	import synth_pkg::*;
;

	// cycle budget per test, plus slack
	localparam int T1_LEN = 60;
	localparam int T2_LEN = 160;
	localparam int T3_LEN = 520;
	localparam int T4_LEN = 440;
	localparam int T5_LEN = 130;
	localparam int CYCLE_LIMIT = T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + 100;

	// demo tune, note and glide per step
	localparam logic [5:0] tune_note [10] = '{6'd12, 6'd24, 6'd36, 6'd24, 6'd36,
		6'd36, 6'd24, 6'd24, 6'd12, 6'd0};
	localparam logic tune_glide [10] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b1,
		1'b1, 1'b1, 1'b1, 1'b1, 1'b1};

	logic clk = 1'b0;
	logic arst_n;
	logic restart;
	logic [1:0] cfg_addr;
	logic cfg_wr;
	logic cfg_rd;
	cfg_word_u cfg_wdata;
	logic [15:0] cfg_rdata;
	logic [7:0] audio_out;
	logic step_tick;

	logic [31:0] lcg_state = 32'd87;
	int n_checks = 0;
	int n_errors = 0;
	int cycles = 0;

	// model state
	logic [15:0] m_period;
	ctrl_t m_ctrl;
	logic [15:0] m_cnt;
	logic [3:0] m_step;
	logic m_tick;
	logic [5:0] m_tnote;
	logic m_tglide;
	logic [5:0] m_lead;
	logic [5:0] m_prev;                     // target seen last cycle
	logic [3:0] m_div;
	logic [19:0] m_ph_lead;
	logic [19:0] m_ph_bass;
	logic [7:0] m_audio;
	logic [15:0] m_rdata;

	synth_top i_dut (.clk(clk), .arst_n(arst_n), .restart(restart), .cfg_addr(cfg_addr),
		.cfg_wr(cfg_wr), .cfg_wdata(cfg_wdata), .cfg_rd(cfg_rd), .cfg_rdata(cfg_rdata),
		.audio_out(audio_out), .step_tick(step_tick));

	always #50 clk = ~clk;

	// hard stop in case a wait never ends
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("simulation timed out after %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic int random_range(input int lo, input int hi);
		return lo + (next_random() % (hi - lo + 1));
	endfunction

	// run, glide_en, vol, chan_en, spare
	function automatic logic [15:0] make_ctrl(input logic run, input logic glide,
		input logic [1:0] vol, input logic [3:0] chan);
		return {run, glide, vol, chan, 8'h00};
	endfunction

	function automatic logic [19:0] note_inc(input logic [5:0] n);
		return semi_inc[n % 12] << (n / 12);    // octave doubles the step
	endfunction

	function automatic logic [5:0] bass_of(input logic [5:0] n);
		return (n >= 12) ? n - 6'd12 : 6'd0;
	endfunction

	function automatic logic [3:0] square_of(input logic [19:0] ph);
		return ph[19] ? 4'hF : 4'h0;
	endfunction

	function automatic logic [3:0] tri_of(input logic [19:0] ph);
		logic [4:0] t;
		t = ph[19:15];
		return t[4] ? ~t[3:0] : t[3:0];         // fold the upper half
	endfunction

	function automatic logic [7:0] mix_audio(input logic [19:0] ph_l, input logic [19:0] ph_b,
		input logic [3:0] en, input logic [1:0] vol);
		int sum;
		sum = 0;
		if (en[3])
			sum += square_of(ph_l);
		if (en[2])
			sum += tri_of(ph_l);
		if (en[1])
			sum += square_of(ph_b);
		if (en[0])
			sum += tri_of(ph_b);
		return 8'(sum * (vol + 1));
	endfunction

	function automatic logic [15:0] model_status();
		return {m_step, m_tnote, m_lead};
	endfunction

	task automatic reset_model();
		m_period = `SYNTH_PERIOD_RESET;
		m_ctrl = make_ctrl(1'b0, 1'b0, 2'd0, 4'hF);
		m_cnt = '0;
		m_step = '0;
		m_tick = 1'b0;
		m_tnote = '0;
		m_tglide = 1'b0;
		m_lead = '0;
		m_prev = '0;
		m_div = '0;
		m_ph_lead = '0;
		m_ph_bass = '0;
		m_audio = '0;
		m_rdata = '0;
	endtask

	// one clk edge of the whole synth, consumers first so they see old state
	task automatic model_update();
		logic gliding;
		m_audio = mix_audio(m_ph_lead, m_ph_bass, m_ctrl.chan_en, m_ctrl.vol);
		if (!cfg_rd)
			m_rdata = '0;
		else if (cfg_addr == 2'd0)
			m_rdata = m_period;
		else if (cfg_addr == 2'd1)
			m_rdata = m_ctrl;
		else if (cfg_addr == 2'd2)
			m_rdata = model_status();
		else
			m_rdata = '0;
		m_ph_lead = m_ph_lead + note_inc(m_lead);
		m_ph_bass = m_ph_bass + note_inc(bass_of(m_tnote));
		// portamento
		gliding = m_ctrl.glide_en && m_tglide;
		if (!gliding)
		begin
			m_lead = m_tnote;
			m_div = '0;
		end
		else if (m_tnote != m_prev)
			m_div = '0;
		else if (m_div == 4'(`SYNTH_GLIDE_DIV - 1))
		begin
			m_div = '0;
			if (m_lead < m_tnote)
				m_lead = m_lead + 6'd1;
			else if (m_lead > m_tnote)
				m_lead = m_lead - 6'd1;
		end
		else
			m_div = m_div + 4'd1;
		m_prev = m_tnote;
		// sequencer
		if (restart)
		begin
			m_cnt = '0;
			m_step = '0;
			m_tick = 1'b0;
			m_tnote = tune_note[0];
			m_tglide = tune_glide[0];
		end
		else if (m_ctrl.run)
		begin
			if (m_cnt == m_period - 16'd1)
			begin
				m_cnt = '0;
				m_step = (m_step == `SYNTH_SEQ_LEN - 1) ? 4'd0 : m_step + 4'd1;
				m_tnote = tune_note[m_step];
				m_tglide = tune_glide[m_step];
				m_tick = ~m_tick;
			end
			else
				m_cnt = m_cnt + 16'd1;
		end
		// register writes land last
		if (cfg_wr && cfg_addr == 2'd0)
			m_period = cfg_wdata.period;
		else if (cfg_wr && cfg_addr == 2'd1)
			m_ctrl = cfg_wdata.period;
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// edge, model step, then compare once the outputs have settled
	task automatic step_cycle();
		@(posedge clk);
		model_update();
		#5;
		check_value("audio_out", audio_out, m_audio);
		check_value("step_tick", step_tick, m_tick);
		check_value("cfg_rdata", cfg_rdata, m_rdata);
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		cfg_addr = addr;
		cfg_wdata.period = data;                // raw view covers both meanings
		cfg_wr = 1'b1;
		step_cycle();
		cfg_wr = 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] addr, output logic [15:0] data);
		cfg_addr = addr;
		cfg_rd = 1'b1;
		step_cycle();
		data = cfg_rdata;
		cfg_rd = 1'b0;
	endtask

	task automatic pulse_restart();
		restart = 1'b1;
		step_cycle();
		restart = 1'b0;
	endtask

	task automatic test_done(input string name);
		$display("test %s finished, errors so far %0d", name, n_errors);
	endtask

	task automatic test_registers();
		logic [15:0] rd;
		logic [15:0] data;
		logic [15:0] exp;
		logic [1:0] addr;
		read_reg(2'd0, rd);
		check_value("reset period", rd, `SYNTH_PERIOD_RESET);
		read_reg(2'd1, rd);
		check_value("reset ctrl", rd, 16'h0F00);     // run 0, vol 0, all channels
		read_reg(2'd2, rd);
		check_value("reset status", rd, 0);
		read_reg(2'd3, rd);
		check_value("unmapped read", rd, 0);
		repeat (8)
		begin
			data = next_random();
			addr = {1'b0, data[0]};
			data = next_random();
			if (addr == 2'd0 && data == 16'd0)
				data = 16'd1;                        // zero period is illegal
			write_reg(addr, data);
			read_reg(addr, rd);
			check_value("readback", rd, data);
		end
		exp = model_status();
		read_reg(2'd2, rd);
		check_value("status read", rd, exp);
		test_done("registers");
	endtask

	task automatic test_step_timing();
		int p;
		int since;
		int toggles;
		logic pending;
		logic prev_tick;
		logic [3:0] exp_step;
		p = random_range(4, 11);
		write_reg(2'd1, make_ctrl(1'b0, 1'b0, 2'd1, 4'hF));
		write_reg(2'd0, 16'(p));
		pulse_restart();
		write_reg(2'd1, make_ctrl(1'b1, 1'b0, 2'd1, 4'hF));
		cfg_addr = 2'd2;                             // watch status every cycle
		cfg_rd = 1'b1;
		since = 0;
		toggles = 0;
		pending = 1'b0;
		exp_step = '0;
		repeat (12 * p + 1)
		begin
			prev_tick = step_tick;
			step_cycle();
			since++;
			if (pending)
			begin
				check_value("status step", cfg_rdata[15:12], exp_step);
				check_value("status target", cfg_rdata[11:6], tune_note[exp_step]);
				pending = 1'b0;
			end
			if (step_tick !== prev_tick)
			begin
				check_value("tick interval", since, p);
				since = 0;
				toggles++;
				exp_step = (exp_step == 4'd9) ? 4'd0 : exp_step + 4'd1;
				pending = 1'b1;              // status shows up one read later
			end
		end
		cfg_rd = 1'b0;
		check_value("tick count", toggles, 12);
		test_done("step timing");
	endtask

	task automatic test_portamento();
		logic [5:0] last_lead;
		logic [5:0] last_tgt;
		logic [5:0] cur_lead;
		logic [5:0] cur_tgt;
		logic seen_move;
		int gap;
		// park on entry 0 with glide off so lead starts at 12
		write_reg(2'd1, make_ctrl(1'b0, 1'b0, 2'd0, 4'hF));
		write_reg(2'd0, 16'd210);
		pulse_restart();
		step_cycle();
		write_reg(2'd1, make_ctrl(1'b1, 1'b1, 2'd0, 4'hF));
		cfg_addr = 2'd2;
		cfg_rd = 1'b1;
		last_lead = 6'd12;
		last_tgt = 6'd12;
		seen_move = 1'b0;
		gap = 0;
		repeat (405)                                 // stop before step 2, which jumps
		begin
			step_cycle();
			gap++;
			cur_lead = cfg_rdata[5:0];
			cur_tgt = cfg_rdata[11:6];
			if (cur_tgt != last_tgt)
				seen_move = 1'b0;
			else if (cur_lead != last_lead)
			begin
				check_value("glide step size",
					(cur_lead > last_lead) ? cur_lead - last_lead : last_lead - cur_lead, 1);
				if (seen_move)
					check_value("glide interval", gap, `SYNTH_GLIDE_DIV);
				seen_move = 1'b1;
				gap = 0;
			end
			last_lead = cur_lead;
			last_tgt = cur_tgt;
		end
		check_value("glide target", cfg_rdata[11:6], 24);
		check_value("glide end note", cfg_rdata[5:0], 24);
		cfg_rd = 1'b0;
		// glide off, lead tracks target one cycle late
		write_reg(2'd1, make_ctrl(1'b1, 1'b0, 2'd0, 4'hF));
		write_reg(2'd0, 16'd20);
		pulse_restart();
		cfg_addr = 2'd2;
		cfg_rd = 1'b1;
		step_cycle();
		last_tgt = cfg_rdata[11:6];
		repeat (70)
		begin
			step_cycle();
			check_value("jump lead", cfg_rdata[5:0], last_tgt);
			last_tgt = cfg_rdata[11:6];
		end
		cfg_rd = 1'b0;
		test_done("portamento");
	endtask

	task automatic test_audio();
		logic [15:0] r;
		write_reg(2'd0, 16'(random_range(3, 15)));
		pulse_restart();
		repeat (8)
		begin
			r = next_random();
			write_reg(2'd1, make_ctrl(1'b1, r[0], r[2:1], r[6:3]));
			repeat (50) step_cycle();               // audio compared every cycle
		end
		test_done("audio");
	endtask

	task automatic test_restart_run();
		logic [15:0] rd;
		logic [3:0] held;
		logic held_tick;
		write_reg(2'd1, make_ctrl(1'b1, 1'b1, 2'd2, 4'hF));
		write_reg(2'd0, 16'd8);
		pulse_restart();
		repeat (30) step_cycle();                   // three steps, tick left high
		pulse_restart();
		check_value("tick after restart", step_tick, 0);
		read_reg(2'd2, rd);
		check_value("step after restart", rd[15:12], 0);
		check_value("target after restart", rd[11:6], tune_note[0]);
		repeat (20) step_cycle();
		write_reg(2'd1, make_ctrl(1'b0, 1'b1, 2'd2, 4'hF));
		read_reg(2'd2, rd);
		held = rd[15:12];
		held_tick = step_tick;
		repeat (40) step_cycle();
		read_reg(2'd2, rd);
		check_value("frozen step", rd[15:12], held);
		check_value("frozen tick", step_tick, held_tick);
		test_done("restart and run");
	endtask

	initial
	begin
		arst_n = 1'b0;
		restart = 1'b0;
		cfg_addr = '0;
		cfg_wr = 1'b0;
		cfg_rd = 1'b0;
		cfg_wdata.period = '0;
		reset_model();
		repeat (2) @(posedge clk);
		#5;
		arst_n = 1'b1;
		test_registers();
		test_step_timing();
		test_portamento();
		test_audio();
		test_restart_run();
		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+.
synth_pkg.sv
synth_regs.sv
note_sequencer.sv
portamento.sv
tone_osc.sv
voice_mixer.sv
synth_top.sv
tb_synth.sv
